//--- design/dds_axil_regs.sv
// dds_axil_regs: axi4-lite slave with ctrl, increment and scale registers
`timescale 1ns/1ps

module dds_axil_regs (
  input  logic                            clk,
  input  logic                            reset,
  // write address and data
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [7:0]                      awaddr,
  input  logic                            wvalid,
  output logic                            wready,
  input  logic [31:0]                     wdata,
  input  logic [3:0]                      wstrb,
  // write response
  output logic                            bvalid,
  input  logic                            bready,
  output logic [1:0]                      bresp,
  // read address and data
  input  logic                            arvalid,
  output logic                            arready,
  input  logic [7:0]                      araddr,
  output logic                            rvalid,
  input  logic                            rready,
  output logic [31:0]                     rdata,
  output logic [1:0]                      rresp,
  // to the core
  output logic                            enable,
  output logic [dds_pkg::phase_width-1:0]  incr_a,
  output logic [dds_pkg::phase_width-1:0]  incr_b,
  output logic [dds_pkg::sample_width-1:0] scale_a,
  output logic [dds_pkg::sample_width-1:0] scale_b
);

  dds_pkg::axil_state_e state;

  logic [dds_pkg::sample_width-1:0] ctrl_reg;
  logic                             wr_hit;
  logic                             wr_en;
  logic                             rd_hit;
  logic [31:0]                      rd_word;

  // only the low two strobes matter, upper half of each word is unused
  function automatic logic [15:0] merge_bytes(input logic [15:0] cur,
                                              input logic [31:0] data,
                                              input logic [3:0]  strb);
    logic [15:0] result;
    result = cur;
    if (strb[0]) begin
      result[7:0] = data[7:0];
    end
    if (strb[1]) begin
      result[15:8] = data[15:8];
    end
    return result;
  endfunction

  // ***********************************************************
  // address decode
  // ***********************************************************
  always_comb begin
    case (awaddr)
      dds_pkg::addr_ctrl, dds_pkg::addr_incr_a, dds_pkg::addr_incr_b,
      dds_pkg::addr_scale_a, dds_pkg::addr_scale_b: wr_hit = 1'b1;
      default: wr_hit = 1'b0;
    endcase
  end

  always_comb begin
    rd_hit  = 1'b1;
    rd_word = '0;
    case (araddr)
      dds_pkg::addr_ctrl:    rd_word[15:0] = ctrl_reg;
      dds_pkg::addr_incr_a:  rd_word[15:0] = incr_a;
      dds_pkg::addr_incr_b:  rd_word[15:0] = incr_b;
      dds_pkg::addr_scale_a: rd_word[15:0] = scale_a;
      dds_pkg::addr_scale_b: rd_word[15:0] = scale_b;
      // unmapped reads return zero
      default:               rd_hit = 1'b0;
    endcase
  end

  // ***********************************************************
  // handshake fsm, one request in flight at a time
  // ***********************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= dds_pkg::st_idle;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= dds_pkg::resp_okay;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
      rresp   <= dds_pkg::resp_okay;
    end else begin
      case (state)
        dds_pkg::st_idle: begin
          // writes need address and data together, and win over reads
          if (awvalid && wvalid) begin
            awready <= 1'b1;
            wready  <= 1'b1;
            state   <= dds_pkg::st_wr_accept;
          end else if (arvalid) begin
            arready <= 1'b1;
            state   <= dds_pkg::st_rd_accept;
          end
        end
        dds_pkg::st_wr_accept: begin
          // handshake completes at this edge
          awready <= 1'b0;
          wready  <= 1'b0;
          bvalid  <= 1'b1;
          bresp   <= wr_hit ? dds_pkg::resp_okay : dds_pkg::resp_slverr;
          state   <= dds_pkg::st_wr_resp;
        end
        dds_pkg::st_wr_resp: begin
          if (bready) begin
            bvalid <= 1'b0;
            state  <= dds_pkg::st_idle;
          end
        end
        dds_pkg::st_rd_accept: begin
          arready <= 1'b0;
          rvalid  <= 1'b1;
          rdata   <= rd_word;
          rresp   <= rd_hit ? dds_pkg::resp_okay : dds_pkg::resp_slverr;
          state   <= dds_pkg::st_rd_resp;
        end
        dds_pkg::st_rd_resp: begin
          if (rready) begin
            rvalid <= 1'b0;
            state  <= dds_pkg::st_idle;
          end
        end
        default: state <= dds_pkg::st_idle;
      endcase
    end
  end

  // ***********************************************************
  // register file
  // ***********************************************************
  assign wr_en = (state == dds_pkg::st_wr_accept);

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_reg <= '0;
      incr_a   <= '0;
      incr_b   <= '0;
      scale_a  <= '0;
      scale_b  <= '0;
    end else if (wr_en) begin
      case (awaddr)
        dds_pkg::addr_ctrl:    ctrl_reg <= merge_bytes(ctrl_reg, wdata, wstrb);
        dds_pkg::addr_incr_a:  incr_a   <= merge_bytes(incr_a, wdata, wstrb);
        dds_pkg::addr_incr_b:  incr_b   <= merge_bytes(incr_b, wdata, wstrb);
        dds_pkg::addr_scale_a: scale_a  <= merge_bytes(scale_a, wdata, wstrb);
        dds_pkg::addr_scale_b: scale_b  <= merge_bytes(scale_b, wdata, wstrb);
        default: ;
      endcase
    end
  end

  // bit 0 of ctrl runs both channels
  assign enable = ctrl_reg[0];

endmodule

//--- design/dds_core.sv
// dds_core: two phase accumulators and tones, saturating sum, valid pipeline
`timescale 1ns/1ps

module dds_core (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            enable,
  input  logic [dds_pkg::phase_width-1:0]  incr_a,
  input  logic [dds_pkg::phase_width-1:0]  incr_b,
  input  logic [dds_pkg::sample_width-1:0] scale_a,
  input  logic [dds_pkg::sample_width-1:0] scale_b,
  output logic [dds_pkg::sample_width-1:0] dds_data,
  output logic                            dds_valid
);

  logic [dds_pkg::phase_width-1:0]      phase_a;
  logic [dds_pkg::phase_width-1:0]      phase_b;
  logic [dds_pkg::sample_width-1:0]     tone_a;
  logic [dds_pkg::sample_width-1:0]     tone_b;
  logic signed [dds_pkg::sample_width:0] sum;
  logic [dds_pkg::sample_width-1:0]     sat;
  logic [dds_pkg::core_latency-1:0]     valid_sr;

  // ***********************************************************
  // channels
  // ***********************************************************
  dds_phase_accum accum_a_i (.clk(clk), .reset(reset), .enable(enable), .incr(incr_a),
                             .phase(phase_a));
  dds_phase_accum accum_b_i (.clk(clk), .reset(reset), .enable(enable), .incr(incr_b),
                             .phase(phase_b));

  dds_tone tone_a_i (.clk(clk), .angle(phase_a), .scale(scale_a), .tone(tone_a));
  dds_tone tone_b_i (.clk(clk), .angle(phase_b), .scale(scale_b), .tone(tone_b));

  // ***********************************************************
  // sum and clamp
  // ***********************************************************
  // one guard bit keeps the raw sum exact
  assign sum = $signed({tone_a[dds_pkg::sample_width-1], tone_a}) +
               $signed({tone_b[dds_pkg::sample_width-1], tone_b});

  always_comb begin
    if (sum > dds_pkg::sat_max) begin
      sat = dds_pkg::sample_width'(dds_pkg::sat_max);
    end else if (sum < dds_pkg::sat_min) begin
      sat = dds_pkg::sample_width'(dds_pkg::sat_min);
    end else begin
      sat = sum[dds_pkg::sample_width-1:0];
    end
  end

  // valid trails enable by the full pipeline depth
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_sr <= '0;
      dds_data <= '0;
    end else begin
      valid_sr <= {valid_sr[dds_pkg::core_latency-2:0], enable};
      // samples outside the valid window are forced to zero
      dds_data <= valid_sr[dds_pkg::core_latency-2] ? sat : '0;
    end
  end

  assign dds_valid = valid_sr[dds_pkg::core_latency-1];

endmodule

//--- design/dds_phase_accum.sv
// dds_phase_accum: wrapping phase accumulator, held at zero while disabled
`timescale 1ns/1ps

module dds_phase_accum (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           enable,
  input  logic [dds_pkg::phase_width-1:0] incr,
  output logic [dds_pkg::phase_width-1:0] phase
);

  // ***********************************************************
  // accumulator
  // ***********************************************************
  // while disabled the phase sits at zero, so the first enabled
  // cycle presents phase zero and later cycles step by incr
  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= '0;
    end else if (!enable) begin
      // restart point for the next enable
      phase <= '0;
    end else begin
      // natural wrap at 2^phase_width, one full turn
      phase <= phase + incr;
    end
  end

endmodule

//--- design/dds_pkg.sv
// dds_pkg: widths, register map, axi enums, fsm states, sine table rule, pipeline depths
package dds_pkg;

  // ***********************************************************
  // widths
  // ***********************************************************
  localparam int phase_width      = 16;
  localparam int sample_width     = 16;
  localparam int table_addr_width = 8;

  // pipeline depths, counted from the angle or phase register
  localparam int sine_latency = 2;
  localparam int tone_latency = 5;
  // one extra register for the saturated sum
  localparam int core_latency = tone_latency + 1;

  // output clamp limits
  localparam int sat_max = 32767;
  localparam int sat_min = -32768;

  // ***********************************************************
  // register map and axi encodings
  // ***********************************************************
  typedef enum logic [7:0] {
    addr_ctrl    = 8'h00,
    addr_incr_a  = 8'h04,
    addr_incr_b  = 8'h08,
    addr_scale_a = 8'h0C,
    addr_scale_b = 8'h10
  } reg_addr_e;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } axi_resp_e;

  typedef enum logic [2:0] {
    st_idle,
    st_wr_accept,
    st_wr_resp,
    st_rd_accept,
    st_rd_resp
  } axil_state_e;

  // quarter wave entry i, sampled half a step off the axis
  function automatic logic [sample_width-1:0] sine_table_value(input int i);
    real step;
    real value;
    step  = 3.14159265358979 / 2.0 * (real'(i) + 0.5) / real'(1 << table_addr_width);
    value = 32767.0 * $sin(step);
    return sample_width'($rtoi(value + 0.5));
  endfunction

endpackage

//--- design/dds_sine_lookup.sv
// dds_sine_lookup: quarter wave sine rom with quadrant mirror and sign, two stages
`timescale 1ns/1ps

module dds_sine_lookup (
  input  logic                            clk,
  input  logic [dds_pkg::phase_width-1:0]  angle,
  output logic [dds_pkg::sample_width-1:0] sine
);

  localparam int table_size = 1 << dds_pkg::table_addr_width;

  logic [dds_pkg::sample_width-1:0]     rom [0:table_size-1];
  logic [1:0]                           quadrant;
  logic [dds_pkg::table_addr_width-1:0] index;
  logic [dds_pkg::table_addr_width-1:0] addr;
  logic [dds_pkg::table_addr_width-1:0] addr_q;
  logic                                 negate_q;

  // ***********************************************************
  // table, filled at elaboration
  // ***********************************************************
  for (genvar i = 0; i < table_size; i++) begin : g_rom
    assign rom[i] = dds_pkg::sine_table_value(i);
  end

  // ***********************************************************
  // angle split
  // ***********************************************************
  // top two bits pick the quadrant, next eight the quarter index
  assign quadrant = angle[dds_pkg::phase_width-1 -: 2];
  assign index    = angle[dds_pkg::phase_width-3 -: dds_pkg::table_addr_width];

  // quadrants 1 and 3 run the quarter backwards
  assign addr = quadrant[0] ? ~index : index;

  // stage one: address and sign
  always_ff @(posedge clk) begin
    addr_q   <= addr;
    // lower half of the circle is negative
    negate_q <= quadrant[1];
  end

  // stage two: signed sample out of the rom
  always_ff @(posedge clk) begin
    if (negate_q) begin
      sine <= -rom[addr_q];
    end else begin
      sine <= rom[addr_q];
    end
  end

endmodule

//--- design/dds_tone.sv
// dds_tone: sine lookup, signed scale multiply and output bit select
`timescale 1ns/1ps

module dds_tone (
  input  logic                            clk,
  input  logic [dds_pkg::phase_width-1:0]  angle,
  input  logic [dds_pkg::sample_width-1:0] scale,
  output logic [dds_pkg::sample_width-1:0] tone
);

  localparam int op_width   = dds_pkg::sample_width + 1;
  localparam int prod_width = 2 * op_width;

  logic [dds_pkg::sample_width-1:0] sine;
  logic [dds_pkg::sample_width-1:0] scale_dly [0:dds_pkg::sine_latency-1];
  logic signed [op_width-1:0]       mul_a;
  logic signed [op_width-1:0]       mul_b;
  logic signed [prod_width-1:0]     product;

  // ***********************************************************
  // sine
  // ***********************************************************
  dds_sine_lookup sine_i (
    .clk   (clk),
    .angle (angle),
    .sine  (sine)
  );

  // scale follows the angle through the lookup so both line up
  always_ff @(posedge clk) begin
    scale_dly[0] <= scale;
    for (int i = 1; i < dds_pkg::sine_latency; i++) begin
      scale_dly[i] <= scale_dly[i-1];
    end
  end

  // ***********************************************************
  // scale multiply
  // ***********************************************************
  // first stage sign-extends and registers both operands
  always_ff @(posedge clk) begin
    mul_a <= {sine[dds_pkg::sample_width-1], sine};
    mul_b <= {scale_dly[dds_pkg::sine_latency-1][dds_pkg::sample_width-1],
              scale_dly[dds_pkg::sine_latency-1]};
  end

  // second stage is the product itself
  always_ff @(posedge clk) begin
    product <= mul_a * mul_b;
  end

  // 16384 is unity, so drop 14 fraction bits
  always_ff @(posedge clk) begin
    tone <= product[29:14];
  end

endmodule

//--- design/dds_top.sv
// dds_top: axi4-lite register block and two tone synthesizer core
`timescale 1ns/1ps

module dds_top (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            awvalid,
  output logic                            awready,
  input  logic [7:0]                      awaddr,
  input  logic                            wvalid,
  output logic                            wready,
  input  logic [31:0]                     wdata,
  input  logic [3:0]                      wstrb,
  output logic                            bvalid,
  input  logic                            bready,
  output logic [1:0]                      bresp,
  input  logic                            arvalid,
  output logic                            arready,
  input  logic [7:0]                      araddr,
  output logic                            rvalid,
  input  logic                            rready,
  output logic [31:0]                     rdata,
  output logic [1:0]                      rresp,
  output logic [dds_pkg::sample_width-1:0] dds_data,
  output logic                            dds_valid
);

  logic                            enable;
  logic [dds_pkg::phase_width-1:0]  incr_a;
  logic [dds_pkg::phase_width-1:0]  incr_b;
  logic [dds_pkg::sample_width-1:0] scale_a;
  logic [dds_pkg::sample_width-1:0] scale_b;

  // register port
  dds_axil_regs regs_i (
    .clk(clk), .reset(reset),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
    .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
    .bvalid(bvalid), .bready(bready), .bresp(bresp),
    .arvalid(arvalid), .arready(arready), .araddr(araddr),
    .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
    .enable(enable), .incr_a(incr_a), .incr_b(incr_b),
    .scale_a(scale_a), .scale_b(scale_b)
  );

  // synthesizer
  dds_core core_i (
    .clk(clk), .reset(reset), .enable(enable),
    .incr_a(incr_a), .incr_b(incr_b), .scale_a(scale_a), .scale_b(scale_b),
    .dds_data(dds_data), .dds_valid(dds_valid)
  );

endmodule

//--- filelist.f
design/dds_pkg.sv
design/dds_axil_regs.sv
design/dds_phase_accum.sv
design/dds_sine_lookup.sv
design/dds_tone.sv
design/dds_core.sv
design/dds_top.sv
tests/dds_checker.sv
tests/dds_tb.sv

//--- tests/dds_checker.sv
// dds_checker: concurrent assertions on axi responses, reset values and the sample stream
`timescale 1ns/1ps

module dds_checker (
  input logic                             clk,
  input logic                             reset,
  input logic                             bvalid,
  input logic                             bready,
  input logic                             rvalid,
  input logic                             rready,
  input logic [dds_pkg::sample_width-1:0] dds_data,
  input logic                             dds_valid
);

  // count of failed assertions
  int fail_count = 0;

  // ***********************************************************
  // axi responses
  // ***********************************************************
  // a response holds until the master takes it
  bvalid_hold: assert property (
    @(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid
  ) else begin
    $error("bvalid dropped before bready");
    fail_count++;
  end

  rvalid_hold: assert property (
    @(posedge clk) disable iff (reset) rvalid && !rready |=> rvalid
  ) else begin
    $error("rvalid dropped before rready");
    fail_count++;
  end

  // reset is synchronous, so flags are low one edge later
  resp_reset: assert property (
    @(posedge clk) reset |=> !bvalid && !rvalid
  ) else begin
    $error("axi response valid while in reset");
    fail_count++;
  end

  // ***********************************************************
  // sample stream
  // ***********************************************************
  valid_reset: assert property (
    @(posedge clk) reset |=> !dds_valid
  ) else begin
    $error("dds_valid high while in reset");
    fail_count++;
  end

  // no stray data between bursts
  data_idle_zero: assert property (
    @(posedge clk) disable iff (reset) !dds_valid |-> dds_data == '0
  ) else begin
    $error("dds_data nonzero while dds_valid is low");
    fail_count++;
  end

endmodule

// attach to the top level
bind dds_top dds_checker chk_i (
  .clk(clk), .reset(reset), .bvalid(bvalid), .bready(bready),
  .rvalid(rvalid), .rready(rready), .dds_data(dds_data), .dds_valid(dds_valid)
);

//--- tests/dds_tb.sv
// dds_tb: clock, reset, axi4-lite master tasks, reference model and five tone tests
`timescale 1ns/1ps

module dds_tb;

  localparam int wait_limit = 100;

  logic        clk, reset, awvalid, wvalid, bready, arvalid, rready;
  logic        awready, wready, bvalid, arready, rvalid, dds_valid;
  logic [7:0]  awaddr, araddr;
  logic [31:0] wdata, rdata;
  logic [3:0]  wstrb;
  logic [1:0]  bresp, rresp;
  logic [15:0] dds_data;
  logic [31:0] rng = 32'd46;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_failed = 0;
  int          checks = 0;
  int          samples [0:63];
  int          single [0:63];

  dds_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ***********************************************************
  // stepping, waiting and checking
  // ***********************************************************
  // inputs change and outputs are read 5 ns after each edge
  task automatic next_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic wait_step(inout int n, input string what);
    next_cycle();
    n++;
    if (n > wait_limit) begin
      $display("timeout at %0t: no %s within %0d cycles", $time, what, wait_limit);
      $display("Something failed");
      $finish;
    end
  endtask

  task automatic check_value(input string what, input int got, input int exp, input int tol);
    checks++;
    assert (got - exp <= tol && exp - got <= tol) else begin
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s: %s, %0d errors", name, test_errors == 0 ? "passed" : "failed",
             test_errors);
    errors += test_errors;
    tests_failed += (test_errors != 0);
    test_errors = 0;
  endtask

  // ***********************************************************
  // axi4-lite master
  // ***********************************************************
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_resp);
    int n;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    n = 0;
    while (!awready) wait_step(n, "write accept");
    // address and data handshake on this edge
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid) wait_step(n, "write response");
    check_value($sformatf("bresp at 0x%h", addr), bresp, exp_resp, 0);
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, input int exp_data,
                          input logic [1:0] exp_resp);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    n = 0;
    while (!arready) wait_step(n, "read accept");
    next_cycle();
    arvalid = 1'b0;
    n = 0;
    while (!rvalid) wait_step(n, "read data");
    check_value($sformatf("rdata at 0x%h", addr), rdata, exp_data, 0);
    check_value($sformatf("rresp at 0x%h", addr), rresp, exp_resp, 0);
    next_cycle();
    rready = 1'b0;
  endtask

  task automatic set_tones(input logic [15:0] inc_a, inc_b, sc_a, sc_b);
    axi_write(8'h04, {16'h0, inc_a}, 2'b00);
    axi_write(8'h08, {16'h0, inc_b}, 2'b00);
    axi_write(8'h0C, {16'h0, sc_a}, 2'b00);
    axi_write(8'h10, {16'h0, sc_b}, 2'b00);
  endtask

  // ctrl bit 0, then wait for the stream to follow
  task automatic set_enable(input bit on);
    int n;
    axi_write(8'h00, {31'b0, on}, 2'b00);
    n = 0;
    while (dds_valid !== on) wait_step(n, on ? "dds_valid rise" : "dds_valid fall");
  endtask

  // ***********************************************************
  // reference model
  // ***********************************************************
  // quarter table mirrored in odd quadrants, negative in the lower half
  function automatic int tone_model(input logic [15:0] phase, input logic [15:0] scale);
    int     idx;
    int     sine;
    longint product;
    idx  = phase[14] ? 255 - phase[13:6] : phase[13:6];
    sine = $rtoi(32767.0 * $sin(3.14159265358979 / 2.0 * (idx + 0.5) / 256.0) + 0.5);
    if (phase[15]) sine = -sine;
    // 16384 is unity, keep bits 29..14
    product = longint'(sine) * longint'($signed(scale));
    return int'($signed(product[29:14]));
  endfunction

  function automatic int sample_model(input int k, input logic [15:0] inc_a, inc_b,
                                      input logic [15:0] sc_a, sc_b);
    int sum;
    sum = tone_model(16'(k * inc_a), sc_a) + tone_model(16'(k * inc_b), sc_b);
    if (sum > dds_pkg::sat_max) sum = dds_pkg::sat_max;
    if (sum < dds_pkg::sat_min) sum = dds_pkg::sat_min;
    return sum;
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // sample k of a burst comes from phase k times the increment
  task automatic check_samples(input logic [15:0] inc_a, inc_b, sc_a, sc_b, input int count);
    for (int k = 0; k < count; k++) begin
      check_value("dds_valid in burst", dds_valid, 1, 0);
      samples[k] = int'($signed(dds_data));
      check_value($sformatf("sample %0d", k), samples[k],
                  sample_model(k, inc_a, inc_b, sc_a, sc_b), 2);
      next_cycle();
    end
  endtask

  // ***********************************************************
  // tests
  // ***********************************************************
  initial begin
    logic [15:0] incr;
    logic [15:0] pair;
    reset   = 1'b1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arvalid = 1'b0;
    rready  = 1'b0;
    awaddr  = '0;
    araddr  = '0;
    wdata   = '0;
    wstrb   = 4'hF;
    repeat (16) @(posedge clk);
    #5;
    reset = 1'b0;

    // registers come up zero, no samples
    for (int i = 0; i < 5; i++) axi_read(8'(4 * i), 0, 2'b00);
    for (int i = 0; i < 20; i++) begin
      check_value("dds_valid after reset", dds_valid, 0, 0);
      next_cycle();
    end
    end_test("reset state");

    // even patterns leave ctrl bit 0 clear, upper half must read zero
    for (int i = 0; i < 5; i++) axi_write(8'(4 * i), {16'hA5A5, 16'(16'h2468 * (i + 1))}, 2'b00);
    for (int i = 0; i < 5; i++) axi_read(8'(4 * i), 16'h2468 * (i + 1), 2'b00);
    axi_write(8'h20, 32'h1234_5678, 2'b10);
    axi_read(8'h20, 0, 2'b10);
    axi_write(8'h00, 32'h0, 2'b00);
    end_test("register access");

    // single tone at unity
    rng  = xorshift(rng);
    // odd step walks every phase
    incr = rng[15:0] | 16'h0001;
    set_tones(incr, incr, 16'h4000, 16'h0000);
    set_enable(1'b1);
    check_samples(incr, incr, 16'h4000, 16'h0000, 64);
    single = samples;
    set_enable(1'b0);
    end_test("single tone");

    // two full scale tones in phase push the sum into the clamp
    rng  = xorshift(rng);
    pair = rng[15:0] | 16'h0001;
    set_tones(pair, pair, 16'h7FFF, 16'h7FFF);
    set_enable(1'b1);
    check_samples(pair, pair, 16'h7FFF, 16'h7FFF, 64);
    set_enable(1'b0);
    end_test("two tones summed");

    // negative unity, restart from phase zero, then silence
    set_tones(incr, incr, 16'hC000, 16'h0000);
    set_enable(1'b1);
    set_enable(1'b0);
    set_enable(1'b1);
    check_samples(incr, incr, 16'hC000, 16'h0000, 64);
    for (int k = 0; k < 64; k++) check_value("negated tone", samples[k], -single[k], 2);
    set_enable(1'b0);
    set_tones(incr, incr, 16'h0000, 16'h0000);
    set_enable(1'b1);
    check_samples(incr, incr, 16'h0000, 16'h0000, 32);
    for (int k = 0; k < 32; k++) check_value("silent sample", samples[k], 0, 0);
    set_enable(1'b0);
    end_test("scale sign and restart");

    errors += dut_i.chk_i.fail_count;
    $display("tests 5, failed %0d, checks %0d, assertion failures %0d, errors %0d",
             tests_failed, checks, dut_i.chk_i.fail_count, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
